// File: rtl/lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    // =========================================================================
    // Sizes
    // =========================================================================
    // Queue entries
    localparam int LSQ_ENTRY_NUM = 8;
    // Max dispatch / retire per cycle
    localparam int DP_NUM        = 2;
    // Commit buffer depth
    localparam int COMMIT_DEPTH  = 4;

    // =========================================================================
    // Vector types
    // =========================================================================
    typedef logic [$clog2(LSQ_ENTRY_NUM)-1:0]   lsq_idx_t;
    // Holds 0 .. LSQ_ENTRY_NUM
    typedef logic [$clog2(LSQ_ENTRY_NUM+1)-1:0] lsq_num_t;
    // One bit per queue entry
    typedef logic [LSQ_ENTRY_NUM-1:0]           lsq_sel_t;
    // Position inside a dispatch bundle
    typedef logic [$clog2(DP_NUM)-1:0]          dp_pos_t;
    // Commit buffer pointer
    typedef logic [$clog2(COMMIT_DEPTH)-1:0]    cmt_ptr_t;
    typedef logic [15:0]                        addr_t;
    typedef logic [31:0]                        data_t;

    typedef enum logic {
        MEM_LOAD,
        MEM_STORE
    } mem_cmd_e;

    // =========================================================================
    // Bundles
    // =========================================================================
    typedef struct packed {
        logic     valid;
        logic     retire;
        mem_cmd_e cmd;
        addr_t    addr;
        data_t    data;
    } lsq_entry_t;

    typedef struct packed {
        mem_cmd_e cmd;
        addr_t    addr;
        data_t    data;
    } dp_slot_t;

    // Slot 0 is the oldest operation
    typedef struct packed {
        lsq_num_t                dp_num;
        dp_slot_t [DP_NUM-1:0]   slot;
    } dp_req_t;

    typedef struct packed {
        lsq_num_t avail_num;
        lsq_idx_t tail;
    } dp_rsp_t;

    typedef struct packed {
        logic     [DP_NUM-1:0] valid;
        lsq_idx_t [DP_NUM-1:0] idx;
    } rob_cmt_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        data_t rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic     valid;
        lsq_idx_t idx;
        data_t    data;
    } ld_done_t;

    // APB master phases
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SETUP,
        ARB_ACCESS
    } arb_state_e;

endpackage

`default_nettype wire

// File: rtl/lsq_ctrl.sv
`default_nettype none

module lsq_ctrl
    import lsq_pkg::*;
(
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,
    input  wire dp_req_t                          dp_req_i,
    input  wire lsq_entry_t [LSQ_ENTRY_NUM-1:0]   lsq_array_i,
    input  wire lsq_num_t                         commit_free_i,
    output dp_rsp_t                               dp_rsp_o,
    output lsq_sel_t                              dp_sel_o,
    output lsq_sel_t                              rt_sel_o,
    output lsq_idx_t                              head_o
);

    // =========================================================================
    // Pointers
    // =========================================================================
    // Index plus rollover bit counts modulo 2*LSQ_ENTRY_NUM
    lsq_idx_t head_q;
    lsq_idx_t tail_q;
    logic     head_roll_q;
    logic     tail_roll_q;

    // Entries between head and tail
    lsq_num_t used_num;
    // Entries leaving this cycle
    lsq_num_t rt_num;
    // Free entries, retiring ones included
    lsq_num_t avail_raw;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_roll_q <= 1'b0;
            tail_roll_q <= 1'b0;
        end else begin
            // Carry out of the index flips the rollover bit
            {head_roll_q, head_q} <= {head_roll_q, head_q} + rt_num;
            {tail_roll_q, tail_q} <= {tail_roll_q, tail_q} + dp_req_i.dp_num;
        end
    end

    // Four-bit difference covers both rollover cases
    assign used_num = {tail_roll_q, tail_q} - {head_roll_q, head_q};

    // =========================================================================
    // Dispatch side
    // =========================================================================
    assign avail_raw = lsq_num_t'(LSQ_ENTRY_NUM) - used_num + rt_num;

    always_comb begin
        // Never offer more than one bundle
        if (avail_raw > lsq_num_t'(DP_NUM)) begin
            dp_rsp_o.avail_num = lsq_num_t'(DP_NUM);
        end else begin
            dp_rsp_o.avail_num = avail_raw;
        end
        dp_rsp_o.tail = tail_q;
    end

    // Contiguous mask from tail that wraps past the last entry
    always_comb begin
        dp_sel_o = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            if (lsq_num_t'(k) < dp_req_i.dp_num) begin
                dp_sel_o[tail_q + lsq_idx_t'(k)] = 1'b1;
            end
        end
    end

    // =========================================================================
    // Retire chain
    // =========================================================================
    always_comb begin
        lsq_idx_t rt_idx;
        logic     chain_ok;

        rt_sel_o = '0;
        rt_num   = '0;
        chain_ok = 1'b1;
        for (int k = 0; k < DP_NUM; k++) begin
            rt_idx = head_q + lsq_idx_t'(k);
            // Inside the queue, retired by ROB, room in commit buffer
            if (chain_ok
                && (lsq_num_t'(k) < used_num)
                && (lsq_num_t'(k) < commit_free_i)
                && lsq_array_i[rt_idx].retire) begin
                rt_sel_o[rt_idx] = 1'b1;
                rt_num           = rt_num + 1'b1;
                // A store ends the chain
                chain_ok         = (lsq_array_i[rt_idx].cmd != MEM_STORE);
            end else begin
                chain_ok = 1'b0;
            end
        end
    end

    assign head_o = head_q;

    // =========================================================================
    // Checks
    // =========================================================================
    // Environment must respect the offered count
    assert property (@(posedge clk_i) disable iff (rst_i)
        dp_req_i.dp_num <= dp_rsp_o.avail_num)
    else $error("lsq_ctrl: dispatch beyond avail_num");

    // Tail never laps head
    assert property (@(posedge clk_i) disable iff (rst_i)
        used_num <= lsq_num_t'(LSQ_ENTRY_NUM))
    else $error("lsq_ctrl: pointers crossed");

endmodule

`default_nettype wire

// File: rtl/lsq_array.sv
`default_nettype none

module lsq_array
    import lsq_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      rst_i,
    input  wire dp_req_t                   dp_req_i,
    input  wire lsq_sel_t                  dp_sel_i,
    input  wire rob_cmt_t                  rob_cmt_i,
    input  wire lsq_sel_t                  rt_sel_i,
    output lsq_entry_t [LSQ_ENTRY_NUM-1:0] entries_o
);

    // Control bits
    lsq_sel_t valid_q;
    lsq_sel_t retire_q;
    // Payload
    mem_cmd_e cmd_q  [LSQ_ENTRY_NUM];
    addr_t    addr_q [LSQ_ENTRY_NUM];
    data_t    data_q [LSQ_ENTRY_NUM];
    // Which bundle slot lands in each entry
    dp_pos_t  dp_pos [LSQ_ENTRY_NUM];

    // Slot number is the run of selected entries just below this one
    always_comb begin
        logic run;

        for (int i = 0; i < LSQ_ENTRY_NUM; i++) begin
            dp_pos[i] = '0;
            run       = 1'b1;
            for (int k = 1; k < DP_NUM; k++) begin
                run = run && dp_sel_i[lsq_idx_t'(i - k)];
                if (run) begin
                    dp_pos[i] = dp_pos[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q  <= '0;
            retire_q <= '0;
        end else begin
            // ROB commit marks the entry
            for (int k = 0; k < DP_NUM; k++) begin
                if (rob_cmt_i.valid[k]) begin
                    retire_q[rob_cmt_i.idx[k]] <= 1'b1;
                end
            end
            // Dispatch into a leaving entry wins over the clear
            for (int i = 0; i < LSQ_ENTRY_NUM; i++) begin
                if (rt_sel_i[i]) begin
                    valid_q[i]  <= 1'b0;
                    retire_q[i] <= 1'b0;
                end
                if (dp_sel_i[i]) begin
                    valid_q[i]  <= 1'b1;
                    retire_q[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < LSQ_ENTRY_NUM; i++) begin
            if (dp_sel_i[i]) begin
                cmd_q[i]  <= dp_req_i.slot[dp_pos[i]].cmd;
                addr_q[i] <= dp_req_i.slot[dp_pos[i]].addr;
                data_q[i] <= dp_req_i.slot[dp_pos[i]].data;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LSQ_ENTRY_NUM; i++) begin
            entries_o[i].valid  = valid_q[i];
            entries_o[i].retire = retire_q[i];
            entries_o[i].cmd    = cmd_q[i];
            entries_o[i].addr   = addr_q[i];
            entries_o[i].data   = data_q[i];
        end
    end

    // ROB may only commit an occupied entry
    for (genvar k = 0; k < DP_NUM; k++) begin : g_cmt_chk
        assert property (@(posedge clk_i) disable iff (rst_i)
            rob_cmt_i.valid[k] |-> valid_q[rob_cmt_i.idx[k]])
        else $error("lsq_array: commit to empty entry %0d", rob_cmt_i.idx[k]);
    end

endmodule

`default_nettype wire

// File: rtl/lsq_commit.sv
`default_nettype none

module lsq_commit
    import lsq_pkg::*;
(
    input  wire logic                             clk_i,
    input  wire logic                             rst_i,
    input  wire lsq_entry_t [LSQ_ENTRY_NUM-1:0]   entries_i,
    input  wire lsq_sel_t                         rt_sel_i,
    input  wire lsq_idx_t                         head_i,
    output lsq_num_t                              free_o,
    output mem_req_t                              mem_req_o,
    input  wire mem_rsp_t                         mem_rsp_i,
    output ld_done_t                              ld_done_o
);

    // =========================================================================
    // Buffer state
    // =========================================================================
    cmt_ptr_t rd_ptr_q;
    cmt_ptr_t wr_ptr_q;
    lsq_num_t cnt_q;

    mem_cmd_e buf_cmd  [COMMIT_DEPTH];
    addr_t    buf_addr [COMMIT_DEPTH];
    data_t    buf_data [COMMIT_DEPTH];
    lsq_idx_t buf_idx  [COMMIT_DEPTH];

    // Push side, one lane per retire slot
    lsq_idx_t              push_idx  [DP_NUM];
    cmt_ptr_t              push_slot [DP_NUM];
    logic     [DP_NUM-1:0] push_vld;
    lsq_num_t              push_num;
    logic                  pop;

    // Retire chain is contiguous from head, so lanes fill in order
    always_comb begin
        push_num = '0;
        for (int k = 0; k < DP_NUM; k++) begin
            push_idx[k]  = head_i + lsq_idx_t'(k);
            push_slot[k] = wr_ptr_q + cmt_ptr_t'(k);
            push_vld[k]  = rt_sel_i[push_idx[k]];
            if (push_vld[k]) begin
                push_num = push_num + 1'b1;
            end
        end
    end

    assign pop    = mem_rsp_i.done;
    assign free_o = lsq_num_t'(COMMIT_DEPTH) - cnt_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + cmt_ptr_t'(push_num);
            rd_ptr_q <= rd_ptr_q + cmt_ptr_t'(pop);
            cnt_q    <= cnt_q + push_num - lsq_num_t'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < DP_NUM; k++) begin
            if (push_vld[k]) begin
                buf_cmd[push_slot[k]]  <= entries_i[push_idx[k]].cmd;
                buf_addr[push_slot[k]] <= entries_i[push_idx[k]].addr;
                buf_data[push_slot[k]] <= entries_i[push_idx[k]].data;
                buf_idx[push_slot[k]]  <= push_idx[k];
            end
        end
    end

    // =========================================================================
    // Memory side
    // =========================================================================
    // Oldest entry held until done
    assign mem_req_o.valid = (cnt_q != '0);
    assign mem_req_o.write = (buf_cmd[rd_ptr_q] == MEM_STORE);
    assign mem_req_o.addr  = buf_addr[rd_ptr_q];
    assign mem_req_o.wdata = buf_data[rd_ptr_q];

    // Load result leaves with the done pulse
    assign ld_done_o.valid = mem_rsp_i.done && (buf_cmd[rd_ptr_q] == MEM_LOAD);
    assign ld_done_o.idx   = buf_idx[rd_ptr_q];
    assign ld_done_o.data  = mem_rsp_i.rdata;

    // Retire cap in lsq_ctrl must keep the buffer from overflowing
    assert property (@(posedge clk_i) disable iff (rst_i)
        push_num <= free_o)
    else $error("lsq_commit: push into full buffer");

endmodule

`default_nettype wire

// File: rtl/mem_apb_arbiter.sv
`default_nettype none

module mem_apb_arbiter
    import lsq_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    input  wire mem_req_t req0_i,
    input  wire mem_req_t req1_i,
    output mem_rsp_t      rsp0_o,
    output mem_rsp_t      rsp1_o,
    output addr_t         paddr_o,
    output logic          pwrite_o,
    output data_t         pwdata_o,
    output logic          psel_o,
    output logic          penable_o,
    input  wire data_t    prdata_i,
    input  wire logic     pready_i
);

    arb_state_e state_q;
    // Port owning the current transfer
    logic       grant_q;
    // Port preferred at the next choice
    logic       prio_q;
    logic       done_q;
    data_t      rdata_q;

    logic       req0_vld;
    logic       req1_vld;
    logic       grant_nxt;
    mem_req_t   req_sel;

    // Port finishing this cycle still shows valid, keep it out
    assign req0_vld = req0_i.valid && !(done_q && !grant_q);
    assign req1_vld = req1_i.valid && !(done_q && grant_q);

    // Round robin pick
    always_comb begin
        if (prio_q) begin
            grant_nxt = req1_vld ? 1'b1 : 1'b0;
        end else begin
            grant_nxt = req0_vld ? 1'b0 : 1'b1;
        end
    end

    // =========================================================================
    // APB master FSM
    // =========================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ARB_IDLE;
            grant_q <= 1'b0;
            prio_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    if (req0_vld || req1_vld) begin
                        grant_q <= grant_nxt;
                        // Other port goes first next time
                        prio_q  <= ~grant_nxt;
                        state_q <= ARB_SETUP;
                    end
                end
                ARB_SETUP: begin
                    state_q <= ARB_ACCESS;
                end
                ARB_ACCESS: begin
                    if (pready_i) begin
                        done_q  <= 1'b1;
                        state_q <= ARB_IDLE;
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    // Read data captured at completion
    always_ff @(posedge clk_i) begin
        if ((state_q == ARB_ACCESS) && pready_i) begin
            rdata_q <= prdata_i;
        end
    end

    // Requester keeps fields stable, so drive straight through
    assign req_sel   = grant_q ? req1_i : req0_i;
    assign paddr_o   = req_sel.addr;
    assign pwrite_o  = req_sel.write;
    assign pwdata_o  = req_sel.wdata;
    assign psel_o    = (state_q != ARB_IDLE);
    assign penable_o = (state_q == ARB_ACCESS);

    assign rsp0_o.done  = done_q && !grant_q;
    assign rsp0_o.rdata = rdata_q;
    assign rsp1_o.done  = done_q && grant_q;
    assign rsp1_o.rdata = rdata_q;

    // Access phase always entered from setup
    assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(penable_o) |-> $past(psel_o && !penable_o))
    else $error("mem_apb_arbiter: penable without setup");

endmodule

`default_nettype wire

// File: rtl/lsq_top.sv
`default_nettype none

module lsq_top
    import lsq_pkg::*;
(
    input  wire logic     clk_i,
    input  wire logic     rst_i,
    // Dispatch and ROB
    input  wire dp_req_t  dp_req_i,
    output dp_rsp_t       dp_rsp_o,
    input  wire rob_cmt_t rob_cmt_i,
    // Host requester
    input  wire mem_req_t host_req_i,
    output mem_rsp_t      host_rsp_o,
    // Load results
    output ld_done_t      ld_done_o,
    // APB master
    output addr_t         paddr_o,
    output logic          pwrite_o,
    output data_t         pwdata_o,
    output logic          psel_o,
    output logic          penable_o,
    input  wire data_t    prdata_i,
    input  wire logic     pready_i
);

    lsq_entry_t [LSQ_ENTRY_NUM-1:0] entries;
    lsq_sel_t                       dp_sel;
    lsq_sel_t                       rt_sel;
    lsq_idx_t                       head;
    lsq_num_t                       commit_free;
    mem_req_t                       cmt_req;
    mem_rsp_t                       cmt_rsp;

    // Pointers and select masks
    lsq_ctrl lsq_ctrl_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .dp_req_i      (dp_req_i),
        .lsq_array_i   (entries),
        .commit_free_i (commit_free),
        .dp_rsp_o      (dp_rsp_o),
        .dp_sel_o      (dp_sel),
        .rt_sel_o      (rt_sel),
        .head_o        (head)
    );

    // Entry storage
    lsq_array lsq_array_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .dp_req_i  (dp_req_i),
        .dp_sel_i  (dp_sel),
        .rob_cmt_i (rob_cmt_i),
        .rt_sel_i  (rt_sel),
        .entries_o (entries)
    );

    // In-order drain to memory
    lsq_commit lsq_commit_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .entries_i (entries),
        .rt_sel_i  (rt_sel),
        .head_i    (head),
        .free_o    (commit_free),
        .mem_req_o (cmt_req),
        .mem_rsp_i (cmt_rsp),
        .ld_done_o (ld_done_o)
    );

    // Port 0 is the commit engine, port 1 the host
    mem_apb_arbiter mem_apb_arbiter_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req0_i    (cmt_req),
        .req1_i    (host_req_i),
        .rsp0_o    (cmt_rsp),
        .rsp1_o    (host_rsp_o),
        .paddr_o   (paddr_o),
        .pwrite_o  (pwrite_o),
        .pwdata_o  (pwdata_o),
        .psel_o    (psel_o),
        .penable_o (penable_o),
        .prdata_i  (prdata_i),
        .pready_i  (pready_i)
    );

endmodule

`default_nettype wire

// File: tb/apb_mem_model.sv
`default_nettype none

module apb_mem_model
    import lsq_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_i,
    input  wire addr_t paddr_i,
    input  wire logic  pwrite_i,
    input  wire data_t pwdata_i,
    input  wire logic  psel_i,
    input  wire logic  penable_i,
    output data_t      prdata_o,
    output logic       pready_o
);

    timeunit 1ns;
    timeprecision 100ps;

    // Full 64K word space
    data_t      mem [65536];
    // Wait states left in the access phase
    logic [1:0] wait_q;

    // Power-up contents, built from every address bit
    function automatic data_t fill_word(addr_t a);
        return {a ^ 16'h5aa5, ~a};
    endfunction

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_word(addr_t'(a));
        end
    end

    always @(posedge clk_i) begin
        if (rst_i) begin
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            // New transfer, draw 0 to 3 wait states
            wait_q <= 2'($urandom % 4);
        end else if (psel_i && penable_i && (wait_q != 2'd0)) begin
            wait_q <= wait_q - 2'd1;
        end
        if (psel_i && penable_i && pready_o && pwrite_i) begin
            mem[paddr_i] <= pwdata_i;
        end
    end

    assign pready_o = psel_i && penable_i && (wait_q == 2'd0);
    assign prdata_o = mem[paddr_i];

endmodule

`default_nettype wire

// File: tb/tb_lsq_top.sv
`default_nettype none

module tb_lsq_top
    import lsq_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROW_NUM  = 22;
    localparam int WAIT_MAX = 2000;

    logic     clk_i;
    logic     rst_i;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    rob_cmt_t rob_cmt;
    mem_req_t host_req;
    mem_rsp_t host_rsp;
    ld_done_t ld_done;
    addr_t    paddr;
    logic     pwrite;
    data_t    pwdata;
    logic     psel;
    logic     penable;
    data_t    prdata;
    logic     pready;

    int       errors;
    int       checks;
    int       disp_done;
    int       loads_seen;
    int       load_total;
    lsq_idx_t rec_idx [ROW_NUM];
    // Expected load results in program order
    lsq_idx_t exp_idx  [$];
    data_t    exp_data [$];
    // Reference memory holds only the words written by the table
    data_t    ref_mem [addr_t];

    // ========================================================================
    // Stimulus table
    // ========================================================================
    dp_slot_t stim [ROW_NUM] = '{
        '{MEM_LOAD,  16'h0010, 32'h0},
        '{MEM_STORE, 16'h0010, 32'h1111_1111},
        '{MEM_LOAD,  16'h0010, 32'h0},
        '{MEM_LOAD,  16'h0020, 32'h0},
        '{MEM_STORE, 16'h0020, 32'h2222_2222},
        '{MEM_STORE, 16'h0024, 32'h3333_3333},
        '{MEM_LOAD,  16'h0024, 32'h0},
        '{MEM_LOAD,  16'h0020, 32'h0},
        '{MEM_STORE, 16'h0030, 32'h4444_4444},
        '{MEM_LOAD,  16'h0030, 32'h0},
        '{MEM_LOAD,  16'h0010, 32'h0},
        '{MEM_STORE, 16'h0010, 32'h5555_5555},
        '{MEM_STORE, 16'h0010, 32'h6666_6666},
        '{MEM_LOAD,  16'h0010, 32'h0},
        '{MEM_LOAD,  16'h0034, 32'h0},
        '{MEM_STORE, 16'h0034, 32'h7777_7777},
        '{MEM_LOAD,  16'h0034, 32'h0},
        '{MEM_LOAD,  16'h0024, 32'h0},
        '{MEM_STORE, 16'h0038, 32'h8888_8888},
        '{MEM_LOAD,  16'h0038, 32'h0},
        '{MEM_LOAD,  16'h0030, 32'h0},
        '{MEM_LOAD,  16'h0014, 32'h0}
    };

    lsq_top lsq_top_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .dp_req_i   (dp_req),
        .dp_rsp_o   (dp_rsp),
        .rob_cmt_i  (rob_cmt),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .ld_done_o  (ld_done),
        .paddr_o    (paddr),
        .pwrite_o   (pwrite),
        .pwdata_o   (pwdata),
        .psel_o     (psel),
        .penable_o  (penable),
        .prdata_i   (prdata),
        .pready_i   (pready)
    );

    apb_mem_model apb_mem_model_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .paddr_i   (paddr),
        .pwrite_i  (pwrite),
        .pwdata_i  (pwdata),
        .psel_i    (psel),
        .penable_i (penable),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    always #4 clk_i = ~clk_i;

    // ========================================================================
    // Reference and compare helpers
    // ========================================================================
    // Same power-up rule as the memory model
    function automatic data_t ref_read(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return {a ^ 16'h5aa5, ~a};
    endfunction

    task automatic check_data(string what, data_t got, data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_idx(string what, lsq_idx_t got, lsq_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_num(string what, lsq_num_t got, lsq_num_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(int num, string name, int err_before);
        $display("Test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "failed");
    endtask

    // Every load result pulse must match the oldest expected load
    always @(posedge clk_i) begin
        if (!rst_i && ld_done.valid) begin
            loads_seen++;
            if (exp_idx.size() == 0) begin
                errors++;
                $display("Unexpected load result for entry %0d", ld_done.idx);
            end else begin
                check_idx("load idx", ld_done.idx, exp_idx.pop_front());
                check_data("load data", ld_done.data, exp_data.pop_front());
            end
        end
    end

    // ========================================================================
    // Drivers
    // ========================================================================
    // Two cycles per row so that tail and avail_num are seen without a
    // dispatch in flight
    task automatic dispatch_row(int row);
        int waited;

        waited = 0;
        forever begin
            @(posedge clk_i);
            if (dp_rsp.avail_num >= lsq_num_t'(1)) begin
                break;
            end
            waited++;
            if (waited > WAIT_MAX) begin
                errors++;
                $display("Timeout waiting for a free entry for row %0d", row);
                return;
            end
        end
        rec_idx[row] = dp_rsp.tail;
        check_idx("dispatch tail", dp_rsp.tail, lsq_idx_t'(row % LSQ_ENTRY_NUM));
        if (stim[row].cmd == MEM_LOAD) begin
            // Queue index is the sequence number modulo the entry count
            exp_idx.push_back(lsq_idx_t'(row % LSQ_ENTRY_NUM));
            exp_data.push_back(ref_read(stim[row].addr));
        end else begin
            ref_mem[stim[row].addr] = stim[row].data;
        end
        dp_req.dp_num  <= lsq_num_t'(1);
        dp_req.slot[0] <= stim[row];
        @(posedge clk_i);
        dp_req.dp_num <= lsq_num_t'(0);
        disp_done = row + 1;
    endtask

    // ROB commits in program order at one per cycle once a row is queued
    task automatic commit_rows(int first);
        int next;
        int waited;

        next   = first;
        waited = 0;
        while (next < ROW_NUM) begin
            @(posedge clk_i);
            if (next < disp_done) begin
                rob_cmt.valid[0] <= 1'b1;
                rob_cmt.idx[0]   <= rec_idx[next];
                next++;
                waited = 0;
            end else begin
                rob_cmt.valid[0] <= 1'b0;
                waited++;
                if (waited > WAIT_MAX) begin
                    errors++;
                    $display("Timeout waiting for row %0d to be dispatched", next);
                    break;
                end
            end
        end
        @(posedge clk_i);
        rob_cmt.valid[0] <= 1'b0;
    endtask

    task automatic host_access(logic wr, addr_t a, data_t d, output data_t rd);
        int waited;

        waited = 0;
        rd     = '0;
        @(posedge clk_i);
        host_req <= '{valid: 1'b1, write: wr, addr: a, wdata: d};
        forever begin
            @(posedge clk_i);
            if (host_rsp.done) begin
                rd = host_rsp.rdata;
                break;
            end
            waited++;
            if (waited > WAIT_MAX) begin
                errors++;
                $display("Timeout waiting for host access to %h", a);
                break;
            end
        end
        host_req.valid <= 1'b0;
    endtask

    task automatic run_host();
        addr_t host_addr [3];
        data_t rd;

        host_addr = '{16'h8000, 16'h8004, 16'h8008};
        for (int i = 0; i < 3; i++) begin
            host_access(1'b1, host_addr[i], 32'hc0de_0000 + i, rd);
        end
        for (int i = 2; i >= 0; i--) begin
            host_access(1'b0, host_addr[i], '0, rd);
            check_data("host read", rd, 32'hc0de_0000 + i);
        end
        // Overwrite then read back
        host_access(1'b1, 16'h8004, 32'hfeed_beef, rd);
        host_access(1'b0, 16'h8004, '0, rd);
        check_data("host reread", rd, 32'hfeed_beef);
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int err_mark;
        int waited;

        void'($urandom(7346));
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        dp_req     = '0;
        rob_cmt    = '0;
        host_req   = '0;
        errors     = 0;
        checks     = 0;
        disp_done  = 0;
        loads_seen = 0;
        load_total = 0;
        for (int i = 0; i < ROW_NUM; i++) begin
            if (stim[i].cmd == MEM_LOAD) begin
                load_total++;
            end
        end
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;

        // Idle state after reset
        err_mark = errors;
        repeat (4) begin
            @(posedge clk_i);
            check_num("avail_num", dp_rsp.avail_num, lsq_num_t'(2));
            check_idx("tail", dp_rsp.tail, lsq_idx_t'(0));
            check_num("psel", lsq_num_t'(psel), lsq_num_t'(0));
            check_num("ld_done valid", lsq_num_t'(ld_done.valid), lsq_num_t'(0));
        end
        report_test(1, "reset state", err_mark);

        // Fill the queue without commits
        err_mark = errors;
        for (int i = 0; i < LSQ_ENTRY_NUM; i++) begin
            dispatch_row(i);
        end
        @(posedge clk_i);
        check_num("avail_num when full", dp_rsp.avail_num, lsq_num_t'(0));
        rob_cmt.valid <= 2'b11;
        rob_cmt.idx   <= {rec_idx[1], rec_idx[0]};
        @(posedge clk_i);
        rob_cmt.valid <= 2'b00;
        waited = 0;
        while (dp_rsp.avail_num != lsq_num_t'(2)) begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_MAX) begin
                errors++;
                $display("Timeout waiting for two entries to retire");
                break;
            end
        end
        report_test(4, "full queue and release", err_mark);

        // Remaining rows, commits and host traffic together
        err_mark = errors;
        fork
            begin
                for (int i = LSQ_ENTRY_NUM; i < ROW_NUM; i++) begin
                    dispatch_row(i);
                end
            end
            commit_rows(2);
            run_host();
        join
        report_test(5, "host traffic", err_mark);

        waited = 0;
        while (loads_seen < load_total) begin
            @(posedge clk_i);
            waited++;
            if (waited > WAIT_MAX) begin
                errors++;
                $display("Timeout waiting for load results, %0d of %0d seen",
                         loads_seen, load_total);
                break;
            end
        end
        if (exp_idx.size() != 0) begin
            errors++;
            $display("Loads left without a result: %0d", exp_idx.size());
        end
        report_test(2, "load data", err_mark);
        report_test(3, "load order and index", err_mark);
        report_test(6, "random wait states", 0);

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/lsq_pkg.sv
rtl/lsq_ctrl.sv
rtl/lsq_array.sv
rtl/lsq_commit.sv
rtl/mem_apb_arbiter.sv
rtl/lsq_top.sv
tb/apb_mem_model.sv
tb/tb_lsq_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LSQ testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_lsq_top -o sim_lsq
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_lsq)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^TEST PASS$"; then
    exit 0
else
    exit 1
fi
